// File: hdl/fetch_mem_pkg.sv
// Widths, handshake structs and address helpers shared by the fetch/memory slice
// L2 always moves one whole line, aligned to LINE_WORDS*4 bytes
package fetch_mem_pkg;

	localparam int unsigned XLEN       = 32;
	localparam int unsigned ILEN       = 32;
	localparam int unsigned LINE_WORDS = 4;

	// Byte offset inside a line and word index inside a line
	localparam int unsigned OFFSET_W   = $clog2(LINE_WORDS * XLEN / 8);
	localparam int unsigned WORD_IDX_W = $clog2(LINE_WORDS);

	// Word i of a line sits at byte offset 4*i
	typedef logic [LINE_WORDS-1:0][XLEN-1:0] line_t;

	// Fetch unit -> icache
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] vaddr;
	} fetch_req_t;

	// Icache -> fetch unit
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] vaddr;
		logic [ILEN-1:0] instr;
	} fetch_ans_t;

	// Line request towards L2
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
	} l2_req_t;

	typedef struct packed {
		logic  valid;
		line_t line;
	} l2_ans_t;

	// Uncached load port of the back end
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
	} ld_req_t;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] data;
	} ld_ans_t;

	function automatic logic [OFFSET_W-1:0] line_offset(input logic [XLEN-1:0] addr);
		return addr[OFFSET_W-1:0];
	endfunction

	function automatic logic [WORD_IDX_W-1:0] word_index(input logic [XLEN-1:0] addr);
		logic [OFFSET_W-1:0] off;
		off = line_offset(addr);
		return off[OFFSET_W-1:2];
	endfunction

	function automatic logic [XLEN-1:0] line_align(input logic [XLEN-1:0] addr);
		return addr - XLEN'(line_offset(addr));
	endfunction

endpackage

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
// Answers must come back in request order; the icache guarantees this
// A redirect may retarget a request that is still waiting for ready
module fetch_unit import fetch_mem_pkg::*; #(
	parameter logic [XLEN-1:0] BOOT_PC           = 32'h0000_1000,
	parameter int unsigned     FETCH_QUEUE_DEPTH = 4
) (
	input  logic            clk_i,
	input  logic            reset_i,
	input  logic            flush_i,
	input  logic            except_i,
	input  logic [XLEN-1:0] except_pc_i,
	output fetch_req_t      fetch_req_o,
	input  logic            fetch_rdy_i,
	input  fetch_ans_t      fetch_ans_i,
	output logic            instr_valid_o,
	output logic [ILEN-1:0] instr_o,
	output logic [XLEN-1:0] instr_pc_o,
	input  logic            instr_ready_i
);

	localparam int unsigned PTR_W = (FETCH_QUEUE_DEPTH > 1) ? $clog2(FETCH_QUEUE_DEPTH) : 1;
	localparam int unsigned CNT_W = $clog2(FETCH_QUEUE_DEPTH + 1);

	logic [XLEN-1:0]  pc_q;
	logic             run_q;
	logic [CNT_W-1:0] pend_cnt_q;
	logic [CNT_W-1:0] pend_cnt_d;
	logic [CNT_W-1:0] stale_cnt_q;
	logic [CNT_W-1:0] q_cnt_q;
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	fetch_ans_t       queue_q [FETCH_QUEUE_DEPTH];
	logic [CNT_W:0]   in_flight;
	logic             redirect;
	logic             req_fire;
	logic             ans_keep;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FETCH_QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign redirect = flush_i | except_i;

	// Queued instructions plus outstanding requests, stale ones included
	assign in_flight = {1'b0, q_cnt_q} + {1'b0, pend_cnt_q};

	assign fetch_req_o.valid = run_q && (in_flight < (CNT_W+1)'(FETCH_QUEUE_DEPTH));
	assign fetch_req_o.vaddr = pc_q;
	assign req_fire = fetch_req_o.valid & fetch_rdy_i;

	// Answers issued before a redirect never reach the queue
	assign ans_keep = fetch_ans_i.valid && (stale_cnt_q == '0) && !redirect;

	assign instr_valid_o = (q_cnt_q != '0);
	assign instr_o       = queue_q[rd_ptr_q].instr;
	assign instr_pc_o    = queue_q[rd_ptr_q].vaddr;
	assign pop           = instr_valid_o & instr_ready_i;

	always_comb begin
		pend_cnt_d = pend_cnt_q;
		if (req_fire && !fetch_ans_i.valid)
			pend_cnt_d = pend_cnt_q + 1'b1;
		else if (!req_fire && fetch_ans_i.valid)
			pend_cnt_d = pend_cnt_q - 1'b1;
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_q        <= BOOT_PC;
			run_q       <= 1'b0;
			pend_cnt_q  <= '0;
			stale_cnt_q <= '0;
			q_cnt_q     <= '0;
			wr_ptr_q    <= '0;
			rd_ptr_q    <= '0;
		end else begin
			run_q      <= 1'b1;
			pend_cnt_q <= pend_cnt_d;

			if (except_i)
				pc_q <= except_pc_i;
			else if (req_fire)
				pc_q <= pc_q + 32'd4;

			if (redirect) begin
				// Everything still outstanding after this cycle is stale
				stale_cnt_q <= pend_cnt_d;
				q_cnt_q     <= '0;
				wr_ptr_q    <= '0;
				rd_ptr_q    <= '0;
			end else begin
				if (fetch_ans_i.valid && (stale_cnt_q != '0))
					stale_cnt_q <= stale_cnt_q - 1'b1;
				if (ans_keep)
					wr_ptr_q <= ptr_inc(wr_ptr_q);
				if (pop)
					rd_ptr_q <= ptr_inc(rd_ptr_q);
				if (ans_keep && !pop)
					q_cnt_q <= q_cnt_q + 1'b1;
				else if (!ans_keep && pop)
					q_cnt_q <= q_cnt_q - 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (ans_keep)
			queue_q[wr_ptr_q] <= fetch_ans_i;
	end

	// A waiting request keeps its address unless a redirect retargets it
	a_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
		(fetch_req_o.valid && !fetch_rdy_i && !redirect)
		|=> (fetch_req_o.valid && $stable(fetch_req_o.vaddr)));

endmodule

// File: hdl/icache.sv
`timescale 1ns/1ps
// Direct-mapped, read-only; NUM_SETS must be a power of two, at least 2
// Blocking: one miss at a time, fetch_rdy_o stays low until the fill is answered
module icache import fetch_mem_pkg::*; #(
	parameter int unsigned NUM_SETS = 8
) (
	input  logic       clk_i,
	input  logic       reset_i,
	input  fetch_req_t fetch_req_i,
	output logic       fetch_rdy_o,
	output fetch_ans_t fetch_ans_o,
	output l2_req_t    l2_req_o,
	input  logic       l2_req_rdy_i,
	input  l2_ans_t    l2_ans_i
);

	localparam int unsigned INDEX_W = $clog2(NUM_SETS);
	localparam int unsigned TAG_W   = XLEN - INDEX_W - OFFSET_W;

	typedef enum logic [1:0] {
		ic_idle,
		ic_miss_req,
		ic_wait_fill
	} ic_state_e;

	ic_state_e           state_q;
	logic [NUM_SETS-1:0] valid_q;
	logic [TAG_W-1:0]    tag_q [NUM_SETS];
	line_t               data_q [NUM_SETS];
	logic [XLEN-1:0]     miss_addr_q;
	logic                ans_valid_q;
	logic [XLEN-1:0]     ans_vaddr_q;
	logic [ILEN-1:0]     ans_instr_q;

	logic [INDEX_W-1:0]  req_idx;
	logic [TAG_W-1:0]    req_tag;
	logic [INDEX_W-1:0]  miss_idx;
	logic [TAG_W-1:0]    miss_tag;
	logic                hit;
	logic                req_fire;
	logic                fill_fire;

	// Address split: tag | index | line offset
	assign req_idx  = fetch_req_i.vaddr[OFFSET_W +: INDEX_W];
	assign req_tag  = fetch_req_i.vaddr[XLEN-1 -: TAG_W];
	assign miss_idx = miss_addr_q[OFFSET_W +: INDEX_W];
	assign miss_tag = miss_addr_q[XLEN-1 -: TAG_W];

	assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

	assign fetch_rdy_o = (state_q == ic_idle);
	assign req_fire    = fetch_req_i.valid && fetch_rdy_o;
	assign fill_fire   = (state_q == ic_wait_fill) && l2_ans_i.valid;

	assign l2_req_o.valid = (state_q == ic_miss_req);
	assign l2_req_o.addr  = line_align(miss_addr_q);

	assign fetch_ans_o.valid = ans_valid_q;
	assign fetch_ans_o.vaddr = ans_vaddr_q;
	assign fetch_ans_o.instr = ans_instr_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q     <= ic_idle;
			valid_q     <= '0;
			ans_valid_q <= 1'b0;
		end else begin
			ans_valid_q <= 1'b0;
			case (state_q)
				ic_idle: begin
					if (req_fire) begin
						if (hit)
							ans_valid_q <= 1'b1;
						else
							state_q <= ic_miss_req;
					end
				end
				ic_miss_req: begin
					if (l2_req_rdy_i)
						state_q <= ic_wait_fill;
				end
				ic_wait_fill: begin
					// Line lands now, the fetch is answered next cycle
					if (l2_ans_i.valid) begin
						valid_q[miss_idx] <= 1'b1;
						ans_valid_q       <= 1'b1;
						state_q           <= ic_idle;
					end
				end
				default: state_q <= ic_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (req_fire) begin
			miss_addr_q <= fetch_req_i.vaddr;
			ans_vaddr_q <= fetch_req_i.vaddr;
			ans_instr_q <= data_q[req_idx][word_index(fetch_req_i.vaddr)];
		end
		if (fill_fire) begin
			tag_q[miss_idx]  <= miss_tag;
			data_q[miss_idx] <= l2_ans_i.line;
			ans_vaddr_q      <= miss_addr_q;
			// Answer straight from the returning line, bypassing the array
			ans_instr_q      <= l2_ans_i.line[word_index(miss_addr_q)];
		end
	end

	// The arbiter must only route a fill here while a miss is pending
	a_no_fill_idle: assert property (@(posedge clk_i) disable iff (reset_i)
		(state_q == ic_idle) |-> !l2_ans_i.valid);

endmodule

// File: hdl/l2_arbiter.sv
`timescale 1ns/1ps
// One L2 transaction at a time; the granted request is registered before it goes out
// Loads fetch the whole line and return only the addressed word
module l2_arbiter import fetch_mem_pkg::*; (
	input  logic    clk_i,
	input  logic    reset_i,
	input  l2_req_t ic_req_i,
	output logic    ic_req_rdy_o,
	output l2_ans_t ic_ans_o,
	input  ld_req_t ld_req_i,
	output logic    ld_req_rdy_o,
	output ld_ans_t ld_ans_o,
	output l2_req_t l2_req_o,
	input  logic    l2_req_rdy_i,
	input  l2_ans_t l2_ans_i,
	output logic    l2_ans_rdy_o
);

	typedef enum logic [1:0] {
		arb_idle,
		arb_req,
		arb_wait
	} arb_state_e;

	arb_state_e            state_q;
	logic                  owner_ld_q;
	logic                  last_ld_q;
	logic [XLEN-1:0]       req_addr_q;
	logic [WORD_IDX_W-1:0] ld_word_q;
	logic                  grant_ic;
	logic                  grant_ld;
	logic                  ans_fire;

	// On a tie the client not served last wins
	always_comb begin
		grant_ic = 1'b0;
		grant_ld = 1'b0;
		if (state_q == arb_idle) begin
			if (ic_req_i.valid && ld_req_i.valid) begin
				grant_ld = !last_ld_q;
				grant_ic = last_ld_q;
			end else begin
				grant_ic = ic_req_i.valid;
				grant_ld = ld_req_i.valid;
			end
		end
	end

	assign ic_req_rdy_o = grant_ic;
	assign ld_req_rdy_o = grant_ld;

	assign l2_req_o.valid = (state_q == arb_req);
	assign l2_req_o.addr  = req_addr_q;
	assign l2_ans_rdy_o   = (state_q == arb_wait);
	assign ans_fire       = l2_ans_i.valid && l2_ans_rdy_o;

	// Route the answer back to whoever owns the transaction
	assign ic_ans_o.valid = ans_fire && !owner_ld_q;
	assign ic_ans_o.line  = l2_ans_i.line;
	assign ld_ans_o.valid = ans_fire && owner_ld_q;
	assign ld_ans_o.data  = l2_ans_i.line[ld_word_q];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q    <= arb_idle;
			owner_ld_q <= 1'b0;
			last_ld_q  <= 1'b0;
		end else begin
			case (state_q)
				arb_idle: begin
					if (grant_ic || grant_ld) begin
						owner_ld_q <= grant_ld;
						last_ld_q  <= grant_ld;
						state_q    <= arb_req;
					end
				end
				arb_req:  if (l2_req_rdy_i) state_q <= arb_wait;
				arb_wait: if (ans_fire) state_q <= arb_idle;
				default:  state_q <= arb_idle;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (grant_ic) begin
			req_addr_q <= line_align(ic_req_i.addr);
		end else if (grant_ld) begin
			req_addr_q <= line_align(ld_req_i.addr);
			ld_word_q  <= word_index(ld_req_i.addr);
		end
	end

	// An L2 answer may only arrive for the one accepted transaction in flight
	a_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
		l2_ans_i.valid |-> (state_q == arb_wait));

endmodule

// File: hdl/data_path_memory.sv
`timescale 1ns/1ps
// Fetch unit, icache and L2 arbiter behind one external L2 port
// The uncached load port shares L2 with icache fills
module data_path_memory import fetch_mem_pkg::*; #(
	parameter logic [XLEN-1:0] BOOT_PC           = 32'h0000_1000,
	parameter int unsigned     NUM_SETS          = 8,
	parameter int unsigned     FETCH_QUEUE_DEPTH = 4
) (
	input  logic            clk_i,
	input  logic            reset_i,
	// Redirects from the back end
	input  logic            flush_i,
	input  logic            except_i,
	input  logic [XLEN-1:0] except_pc_i,
	// In-order instruction stream
	output logic            instr_valid_o,
	output logic [ILEN-1:0] instr_o,
	output logic [XLEN-1:0] instr_pc_o,
	input  logic            instr_ready_i,
	// Uncached loads
	input  ld_req_t         ld_req_i,
	output logic            ld_req_rdy_o,
	output ld_ans_t         ld_ans_o,
	// External L2
	output l2_req_t         l2_req_o,
	input  logic            l2_req_rdy_i,
	input  l2_ans_t         l2_ans_i,
	output logic            l2_ans_rdy_o
);

	fetch_req_t fetch_req;
	logic       fetch_rdy;
	fetch_ans_t fetch_ans;
	l2_req_t    ic_l2_req;
	logic       ic_l2_req_rdy;
	l2_ans_t    ic_l2_ans;

	fetch_unit #(
		.BOOT_PC          (BOOT_PC),
		.FETCH_QUEUE_DEPTH(FETCH_QUEUE_DEPTH)
	) u_fetch_unit (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.flush_i      (flush_i),
		.except_i     (except_i),
		.except_pc_i  (except_pc_i),
		.fetch_req_o  (fetch_req),
		.fetch_rdy_i  (fetch_rdy),
		.fetch_ans_i  (fetch_ans),
		.instr_valid_o(instr_valid_o),
		.instr_o      (instr_o),
		.instr_pc_o   (instr_pc_o),
		.instr_ready_i(instr_ready_i)
	);

	icache #(
		.NUM_SETS(NUM_SETS)
	) u_icache (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.fetch_req_i (fetch_req),
		.fetch_rdy_o (fetch_rdy),
		.fetch_ans_o (fetch_ans),
		.l2_req_o    (ic_l2_req),
		.l2_req_rdy_i(ic_l2_req_rdy),
		.l2_ans_i    (ic_l2_ans)
	);

	l2_arbiter u_l2_arbiter (
		.clk_i       (clk_i),
		.reset_i     (reset_i),
		.ic_req_i    (ic_l2_req),
		.ic_req_rdy_o(ic_l2_req_rdy),
		.ic_ans_o    (ic_l2_ans),
		.ld_req_i    (ld_req_i),
		.ld_req_rdy_o(ld_req_rdy_o),
		.ld_ans_o    (ld_ans_o),
		.l2_req_o    (l2_req_o),
		.l2_req_rdy_i(l2_req_rdy_i),
		.l2_ans_i    (l2_ans_i),
		.l2_ans_rdy_o(l2_ans_rdy_o)
	);

endmodule

// File: verification/fetch_mem_checker.sv
`timescale 1ns/1ps
// Predicts the instruction stream and load data from the address pattern of the L2 model
// Also sees the internal fetch request, which is needed to predict where a flush resumes
module fetch_mem_checker import fetch_mem_pkg::*; #(
	parameter logic [XLEN-1:0] BOOT_PC = 32'h0000_1000
) (
	input  logic            clk_i,
	input  logic            reset_i,
	input  logic            flush_i,
	input  logic            except_i,
	input  logic [XLEN-1:0] except_pc_i,
	input  fetch_req_t      fetch_req_i,
	input  logic            fetch_rdy_i,
	input  logic            instr_valid_i,
	input  logic [ILEN-1:0] instr_i,
	input  logic [XLEN-1:0] instr_pc_i,
	input  logic            instr_ready_i,
	input  ld_req_t         ld_req_i,
	input  logic            ld_req_rdy_i,
	input  ld_ans_t         ld_ans_i,
	input  l2_req_t         l2_req_i,
	input  logic            l2_req_rdy_i,
	input  logic            l2_ans_rdy_i,
	output int              instr_errs_o,
	output int              load_errs_o,
	output int              proto_errs_o
);

	localparam logic [XLEN-1:0] PATTERN = 32'hA5A5_0000;

	int              instr_errs = 0;
	int              load_errs  = 0;
	int              proto_errs = 0;
	logic [XLEN-1:0] exp_pc     = BOOT_PC;
	logic [XLEN-1:0] next_fetch = BOOT_PC;
	logic [XLEN-1:0] ld_exp [$];
	logic            in_reset_q = 1'b0;
	logic            hold_q     = 1'b0;
	logic [ILEN-1:0] held_instr;
	logic [XLEN-1:0] held_pc;
	logic            l2_wait_q  = 1'b0;
	logic [XLEN-1:0] l2_addr_q;

	assign instr_errs_o = instr_errs;
	assign load_errs_o  = load_errs;
	assign proto_errs_o = proto_errs;

	function automatic int check_value(input string name, input logic [XLEN-1:0] expected,
			input logic [XLEN-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s expected %h got %h", name, expected, actual);
			return 1;
		end
		return 0;
	endfunction

	// All DUT outputs are sampled at the rising edge, before the design updates
	always @(posedge clk_i) begin
		in_reset_q <= reset_i;
		// Values just after a reset edge
		if (in_reset_q) begin
			proto_errs += check_value("instr_valid_o", 0, instr_valid_i);
			proto_errs += check_value("l2_req_o.valid", 0, l2_req_i.valid);
			proto_errs += check_value("ld_ans_o.valid", 0, ld_ans_i.valid);
			proto_errs += check_value("l2_ans_rdy_o", 0, l2_ans_rdy_i);
		end
		if (reset_i) begin
			hold_q    <= 1'b0;
			l2_wait_q <= 1'b0;
		end else begin
			// A stalled instruction must not move
			if (hold_q) begin
				proto_errs += check_value("instr_valid_o", 1, instr_valid_i);
				instr_errs += check_value("instr_o", held_instr, instr_i);
				instr_errs += check_value("instr_pc_o", held_pc, instr_pc_i);
			end
			hold_q     <= instr_valid_i && !instr_ready_i && !flush_i && !except_i;
			held_instr <= instr_i;
			held_pc    <= instr_pc_i;

			if (instr_valid_i && instr_ready_i) begin
				instr_errs += check_value("instr_pc_o", exp_pc, instr_pc_i);
				instr_errs += check_value("instr_o", exp_pc ^ PATTERN, instr_i);
				exp_pc = exp_pc + 32'd4;
			end

			// Next address to be fetched, which is where delivery resumes after a redirect
			if (except_i)
				next_fetch = except_pc_i;
			else if (fetch_req_i.valid && fetch_rdy_i)
				next_fetch = next_fetch + 32'd4;
			if (flush_i || except_i)
				exp_pc = next_fetch;

			if (ld_ans_i.valid) begin
				if (ld_exp.size() == 0) begin
					$display("Load answer arrived while no load was outstanding");
					load_errs++;
				end else begin
					load_errs += check_value("ld_ans_o.data", ld_exp.pop_front(), ld_ans_i.data);
				end
			end
			if (ld_req_i.valid && ld_req_rdy_i)
				ld_exp.push_back((ld_req_i.addr & ~32'h3) ^ PATTERN);

			// L2 request must hold while it waits for ready
			if (l2_wait_q) begin
				proto_errs += check_value("l2_req_o.valid", 1, l2_req_i.valid);
				proto_errs += check_value("l2_req_o.addr", l2_addr_q, l2_req_i.addr);
			end
			l2_wait_q <= l2_req_i.valid && !l2_req_rdy_i;
			l2_addr_q <= l2_req_i.addr;
		end
	end

endmodule

// File: verification/tb_data_path_memory.sv
`timescale 1ns/1ps
// Table-driven run of the fetch/memory slice against a random-latency L2 model
// Every L2 word equals its byte address XOR 32'hA5A5_0000
module tb_data_path_memory;
	import fetch_mem_pkg::*;

	localparam logic [XLEN-1:0] BOOT_PC     = 32'h0000_1000;
	localparam int              NUM_ROWS    = 8;
	localparam int              CYCLE_LIMIT = 200 * NUM_ROWS;

	typedef enum logic [1:0] {
		rd_none,
		rd_except,
		rd_flush
	} redirect_e;

	// One step: redirect, then an optional load (address 0 means none) alongside consumption
	typedef struct packed {
		redirect_e       kind;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] ld_addr;
		logic [7:0]      stall;
		logic [7:0]      count;
	} row_t;

	logic            clk_i;
	logic            reset_i;
	logic            flush_i;
	logic            except_i;
	logic [XLEN-1:0] except_pc_i;
	logic            instr_valid_o;
	logic [ILEN-1:0] instr_o;
	logic [XLEN-1:0] instr_pc_o;
	logic            instr_ready_i;
	ld_req_t         ld_req_i;
	logic            ld_req_rdy_o;
	ld_ans_t         ld_ans_o;
	l2_req_t         l2_req_o;
	logic            l2_req_rdy_i;
	l2_ans_t         l2_ans_i;
	logic            l2_ans_rdy_o;

	row_t            rows [NUM_ROWS];
	int              cycle_cnt = 0;
	int              instr_errs;
	int              load_errs;
	int              proto_errs;

	data_path_memory #(
		.BOOT_PC(BOOT_PC)
	) DUT (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.flush_i      (flush_i),
		.except_i     (except_i),
		.except_pc_i  (except_pc_i),
		.instr_valid_o(instr_valid_o),
		.instr_o      (instr_o),
		.instr_pc_o   (instr_pc_o),
		.instr_ready_i(instr_ready_i),
		.ld_req_i     (ld_req_i),
		.ld_req_rdy_o (ld_req_rdy_o),
		.ld_ans_o     (ld_ans_o),
		.l2_req_o     (l2_req_o),
		.l2_req_rdy_i (l2_req_rdy_i),
		.l2_ans_i     (l2_ans_i),
		.l2_ans_rdy_o (l2_ans_rdy_o)
	);

	fetch_mem_checker #(
		.BOOT_PC(BOOT_PC)
	) u_checker (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.flush_i      (flush_i),
		.except_i     (except_i),
		.except_pc_i  (except_pc_i),
		.fetch_req_i  (DUT.fetch_req),
		.fetch_rdy_i  (DUT.fetch_rdy),
		.instr_valid_i(instr_valid_o),
		.instr_i      (instr_o),
		.instr_pc_i   (instr_pc_o),
		.instr_ready_i(instr_ready_i),
		.ld_req_i     (ld_req_i),
		.ld_req_rdy_i (ld_req_rdy_o),
		.ld_ans_i     (ld_ans_o),
		.l2_req_i     (l2_req_o),
		.l2_req_rdy_i (l2_req_rdy_i),
		.l2_ans_rdy_i (l2_ans_rdy_o),
		.instr_errs_o (instr_errs),
		.load_errs_o  (load_errs),
		.proto_errs_o (proto_errs)
	);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic line_t make_line(input logic [XLEN-1:0] addr);
		line_t           line;
		logic [XLEN-1:0] base;
		base = addr & ~(XLEN'(LINE_WORDS * 4 - 1));
		for (int i = 0; i < LINE_WORDS; i++)
			line[i] = (base + XLEN'(4 * i)) ^ 32'hA5A5_0000;
		return line;
	endfunction

	// L2 model: random ready stall, then a random delay before the line comes back
	initial begin
		logic [XLEN-1:0] addr;
		forever begin
			@(negedge clk_i);
			if (!reset_i && l2_req_o.valid) begin
				repeat ($urandom % 6) @(negedge clk_i);
				addr         = l2_req_o.addr;
				l2_req_rdy_i = 1'b1;
				@(negedge clk_i);
				l2_req_rdy_i = 1'b0;
				repeat ($urandom % 6) @(negedge clk_i);
				l2_ans_i.valid = 1'b1;
				l2_ans_i.line  = make_line(addr);
				@(posedge clk_i);
				while (!l2_ans_rdy_o)
					@(posedge clk_i);
				@(negedge clk_i);
				l2_ans_i = '0;
			end
		end
	end

	// Tasks below start and end on a falling edge
	task automatic apply_redirect(input redirect_e kind, input logic [XLEN-1:0] pc);
		if (kind == rd_none)
			return;
		except_pc_i = pc;
		except_i    = (kind == rd_except);
		flush_i     = (kind == rd_flush);
		@(negedge clk_i);
		except_i = 1'b0;
		flush_i  = 1'b0;
	endtask

	task automatic drive_load(input logic [XLEN-1:0] addr);
		if (addr == '0)
			return;
		ld_req_i.valid = 1'b1;
		ld_req_i.addr  = addr;
		@(posedge clk_i);
		while (!ld_req_rdy_o)
			@(posedge clk_i);
		@(negedge clk_i);
		ld_req_i = '0;
		@(posedge clk_i);
		while (!ld_ans_o.valid)
			@(posedge clk_i);
	endtask

	task automatic consume_instrs(input int stall, input int count);
		int got;
		got = 0;
		instr_ready_i = 1'b0;
		repeat (stall) @(negedge clk_i);
		instr_ready_i = 1'b1;
		while (got < count) begin
			@(posedge clk_i);
			if (instr_valid_o)
				got++;
		end
		@(negedge clk_i);
		instr_ready_i = 1'b0;
	endtask

	initial begin
		void'($urandom(32'h6ec0_3363));
		reset_i       = 1'b1;
		flush_i       = 1'b0;
		except_i      = 1'b0;
		except_pc_i   = '0;
		instr_ready_i = 1'b0;
		ld_req_i      = '0;
		l2_req_rdy_i  = 1'b0;
		l2_ans_i      = '0;

		// Cold misses, then loads racing fills, redirects and a conflict on set 0
		rows[0] = '{rd_none,   32'h0,         32'h0,         8'd0, 8'd6};
		rows[1] = '{rd_none,   32'h0,         32'h0000_3004, 8'd3, 8'd5};
		rows[2] = '{rd_except, 32'h0000_2000, 32'h0000_500C, 8'd0, 8'd6};
		rows[3] = '{rd_flush,  32'h0,         32'h0000_1008, 8'd4, 8'd5};
		rows[4] = '{rd_except, 32'h0000_1000, 32'h0,         8'd2, 8'd8};
		rows[5] = '{rd_except, 32'h0000_1800, 32'h0000_6008, 8'd1, 8'd5};
		rows[6] = '{rd_flush,  32'h0,         32'h0000_7000, 8'd5, 8'd4};
		rows[7] = '{rd_none,   32'h0,         32'h0000_2004, 8'd0, 8'd6};

		repeat (4) @(posedge clk_i);
		@(negedge clk_i);
		reset_i = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			apply_redirect(rows[r].kind, rows[r].pc);
			fork
				drive_load(rows[r].ld_addr);
				consume_instrs(int'(rows[r].stall), int'(rows[r].count));
			join
			@(negedge clk_i);
		end

		$display("Error counts: instruction %0d, load %0d, protocol %0d",
			instr_errs, load_errs, proto_errs);
		if (instr_errs + load_errs + proto_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: data_path_memory.f
hdl/fetch_mem_pkg.sv
hdl/fetch_unit.sv
hdl/icache.sv
hdl/l2_arbiter.sv
hdl/data_path_memory.sv
verification/fetch_mem_checker.sv
verification/tb_data_path_memory.sv

// File: Bender.yml
package:
  name: data_path_memory

sources:
  - files:
      - hdl/fetch_mem_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/icache.sv
      - hdl/l2_arbiter.sv
      - hdl/data_path_memory.sv
  - target: test
    files:
      - verification/fetch_mem_checker.sv
      - verification/tb_data_path_memory.sv
